/* list.f */
verilog/mc_pkg.sv
verilog/mc_if.sv
verilog/msg_queue.sv
verilog/coherence_ingress.sv
verilog/mem_issue_ctrl.sv
verilog/response_egress.sv
verilog/mem_controller_top.sv
test/mc_sva.sv
test/mc_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it, a failing run gives a nonzero status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mc_tb -f list.f -o mc_sim &&
./obj_dir/mc_sim || exit 1

/* test/mc_sva.sv */
// Handshake rules of the issue controller. The module is bound to every mem_issue_ctrl instance.
// All checks are off while reset is high.

`timescale 1ns/1ns

module mc_sva (
	input logic                clk,
	input logic                reset,
	input logic                mem_read,
	input logic                mem_write,
	input logic                fwd_pop,
	input logic                wb_pop,
	input logic                fwd_valid,
	input logic                wb_valid,
	input mc_pkg::ctrl_state_t state
);

	// Only one memory strobe at a time
	no_dual_strobe: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write are high in the same cycle");

	read_one_cycle: assert property (@(posedge clk) disable iff (reset)
		mem_read |=> !mem_read)
		else $error("mem_read stayed high for more than one cycle");

	write_one_cycle: assert property (@(posedge clk) disable iff (reset)
		mem_write |=> !mem_write)
		else $error("mem_write stayed high for more than one cycle");

	// A queue head leaves only from a non-empty queue in its own ISSUE state
	fwd_pop_in_issue: assert property (@(posedge clk) disable iff (reset)
		fwd_pop |-> (state == mc_pkg::ISSUE_READ && fwd_valid))
		else $error("Forwarded queue pop outside ISSUE_READ or from an empty queue");

	wb_pop_in_issue: assert property (@(posedge clk) disable iff (reset)
		wb_pop |-> (state == mc_pkg::ISSUE_WRITE && wb_valid))
		else $error("Writeback queue pop outside ISSUE_WRITE or from an empty queue");

endmodule

bind mem_issue_ctrl mc_sva issue_checks (
	.clk       (clk),
	.reset     (reset),
	.mem_read  (mem_read),
	.mem_write (mem_write),
	.fwd_pop   (fwd.pop),
	.wb_pop    (wb.pop),
	.fwd_valid (fwd.valid),
	.wb_valid  (wb.valid),
	.state     (state)
);

/* test/mc_tb.sv */
// Testbench for the memory controller bridge with a memory that answers reads two cycles later.
// Reads in flight never share an address with a pending writeback, so reference lines are exact.

`timescale 1ns/1ns

module mc_tb;

	localparam int               ADDR_WIDTH = 32;
	localparam int               LINE_WIDTH = 512;
	localparam int               MASK_WIDTH = 64;
	localparam int               CLK_PERIOD = 4;
	localparam int               NUM_TXNS   = 16;
	localparam logic [31:0]      SEED       = 32'h0f0b9910;
	localparam mc_pkg::tile_id_t TB_TILE    = 4'd5;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		mc_pkg::tile_id_t      dest;
		logic [LINE_WIDTH-1:0] data;
	} resp_exp_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [LINE_WIDTH-1:0] data;
		logic [MASK_WIDTH-1:0] mask;
	} write_exp_t;

	logic                  clk;
	logic                  reset;
	logic                  fwd_valid;
	logic [ADDR_WIDTH-1:0] fwd_addr;
	mc_pkg::tile_id_t      fwd_src;
	logic                  fwd_ready;
	logic                  wb_valid;
	logic [ADDR_WIDTH-1:0] wb_addr;
	logic [LINE_WIDTH-1:0] wb_data;
	logic [MASK_WIDTH-1:0] wb_mask;
	mc_pkg::tile_id_t      wb_src;
	logic                  wb_ready;
	logic [ADDR_WIDTH-1:0] mem_addr;
	logic [LINE_WIDTH-1:0] mem_wdata;
	logic [MASK_WIDTH-1:0] mem_mask;
	logic                  mem_read;
	logic                  mem_write;
	logic                  mem_read_ready;
	logic                  mem_write_ready;
	logic                  mem_resp_valid;
	logic [LINE_WIDTH-1:0] mem_resp_data;
	logic                  mem_resp_ready;
	logic                  resp_ready;
	logic                  resp_valid;
	mc_pkg::resp_kind_t    resp_kind;
	logic [ADDR_WIDTH-1:0] resp_addr;
	logic [LINE_WIDTH-1:0] resp_data;
	mc_pkg::tile_id_t      resp_dest;
	mc_pkg::tile_id_t      resp_src;

	// One queue of expected traffic per kind enforces only the per-kind order
	resp_exp_t             exp_data[$];
	resp_exp_t             exp_ack[$];
	logic [ADDR_WIDTH-1:0] exp_rd[$];
	write_exp_t            exp_wr[$];
	logic [LINE_WIDTH-1:0] lines[logic [ADDR_WIDTH-1:0]];

	string                 test_name;
	int                    rd_delay;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic                  resp_ready_prev;
	logic [31:0]           rng;
	logic [LINE_WIDTH-1:0] wb_line;

	mem_controller_top #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.LINE_WIDTH  (LINE_WIDTH),
		.MASK_WIDTH  (MASK_WIDTH),
		.QUEUE_DEPTH (4),
		.TILE_ID     (TB_TILE)
	) uut (
		.clk (clk), .reset (reset),
		.fwd_valid (fwd_valid), .fwd_addr (fwd_addr), .fwd_src (fwd_src), .fwd_ready (fwd_ready),
		.wb_valid (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data), .wb_mask (wb_mask),
		.wb_src (wb_src), .wb_ready (wb_ready),
		.mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_mask (mem_mask),
		.mem_read (mem_read), .mem_write (mem_write),
		.mem_read_ready (mem_read_ready), .mem_write_ready (mem_write_ready),
		.mem_resp_valid (mem_resp_valid), .mem_resp_data (mem_resp_data),
		.mem_resp_ready (mem_resp_ready),
		.resp_ready (resp_ready), .resp_valid (resp_valid), .resp_kind (resp_kind),
		.resp_addr (resp_addr), .resp_data (resp_data),
		.resp_dest (resp_dest), .resp_src (resp_src)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Reference memory contents are the written line or else a pattern seeded by the address
	function automatic logic [LINE_WIDTH-1:0] expected_line(input logic [ADDR_WIDTH-1:0] addr);
		logic [LINE_WIDTH-1:0] line;
		logic [31:0]           s;
		if (lines.exists(addr))
			return lines[addr];
		s = SEED ^ addr;
		for (int i = 0; i < LINE_WIDTH / 32; i++) begin
			s = lcg_next(s);
			line[i*32 +: 32] = s ^ addr;
		end
		return line;
	endfunction

	// Only the bytes marked dirty replace the old line
	function automatic logic [LINE_WIDTH-1:0] merge_line(input logic [LINE_WIDTH-1:0] old,
		input logic [LINE_WIDTH-1:0] data, input logic [MASK_WIDTH-1:0] mask);
		logic [LINE_WIDTH-1:0] line;
		line = old;
		for (int b = 0; b < MASK_WIDTH; b++) begin
			if (mask[b])
				line[b*8 +: 8] = data[b*8 +: 8];
		end
		return line;
	endfunction

	task automatic random_line(output logic [LINE_WIDTH-1:0] line);
		for (int i = 0; i < LINE_WIDTH / 32; i++) begin
			rng = lcg_next(rng);
			line[i*32 +: 32] = rng;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string field, input logic [LINE_WIDTH-1:0] expected,
		input logic [LINE_WIDTH-1:0] actual);
		assert (actual == expected) else
			abort_run($sformatf("CHECK FAILED %s %s expected %0h actual %0h",
				test_name, field, expected, actual));
	endtask

	task automatic check_idle_outputs();
		check_value("mem_read", 0, mem_read);
		check_value("mem_write", 0, mem_write);
		check_value("resp_valid", 0, resp_valid);
		check_value("fwd_ready", 1, fwd_ready);
		check_value("wb_ready", 1, wb_ready);
	endtask

	// Tasks start and end 1 ns after a rising edge
	task automatic send_read(input logic [ADDR_WIDTH-1:0] addr, input mc_pkg::tile_id_t src);
		resp_exp_t e;
		fwd_valid = 1'b1;
		fwd_addr  = addr;
		fwd_src   = src;
		@(negedge clk);
		while (!fwd_ready)
			@(negedge clk);
		e.addr = addr;
		e.dest = src;
		e.data = expected_line(addr);
		exp_rd.push_back(addr);
		exp_data.push_back(e);
		@(posedge clk);
		#1;
		fwd_valid = 1'b0;
	endtask

	task automatic send_write(input logic [ADDR_WIDTH-1:0] addr,
		input logic [LINE_WIDTH-1:0] data, input logic [MASK_WIDTH-1:0] mask,
		input mc_pkg::tile_id_t src);
		resp_exp_t  e;
		write_exp_t w;
		wb_valid = 1'b1;
		wb_addr  = addr;
		wb_data  = data;
		wb_mask  = mask;
		wb_src   = src;
		@(negedge clk);
		while (!wb_ready)
			@(negedge clk);
		w.addr = addr;
		w.data = data;
		w.mask = mask;
		e.addr = addr;
		e.dest = src;
		e.data = '0;
		exp_wr.push_back(w);
		exp_ack.push_back(e);
		lines[addr] = merge_line(expected_line(addr), data, mask);
		@(posedge clk);
		#1;
		wb_valid = 1'b0;
	endtask

	task automatic wait_all_done();
		while (exp_data.size() + exp_ack.size() + exp_rd.size() + exp_wr.size() > 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
	endtask

	// Memory read data returns two cycles after the strobe
	always @(posedge clk) begin
		#1;
		mem_resp_valid = (rd_delay == 1);
		mem_resp_data  = (rd_delay == 1) ? expected_line(rd_addr) : '0;
		if (rd_delay > 0)
			rd_delay--;
	end

	always @(negedge clk) begin : compare_traffic
		resp_exp_t  e;
		write_exp_t w;
		if (!reset) begin
			if (mem_read) begin
				assert (mem_read_ready && exp_rd.size() > 0) else
					abort_run("Memory read issued while memory was busy or with no read pending");
				check_value("mem_read address", exp_rd.pop_front(), mem_addr);
				rd_delay = 2;
				rd_addr  = mem_addr;
			end
			if (mem_write) begin
				assert (mem_write_ready && exp_wr.size() > 0) else
					abort_run("Memory write issued while memory was busy or with no writeback pending");
				w = exp_wr.pop_front();
				check_value("mem_write address", w.addr, mem_addr);
				check_value("mem_write data", w.data, mem_wdata);
				check_value("mem_write mask", w.mask, mem_mask);
			end
			if (mem_resp_valid) begin
				assert (mem_resp_ready) else
					abort_run("Memory data arrived while the data queue was not ready");
			end
			if (resp_valid) begin
				assert (resp_ready_prev) else
					abort_run("Response sent without resp_ready in the cycle before");
				if (resp_kind == mc_pkg::RESP_DATA) begin
					assert (exp_data.size() > 0) else
						abort_run("DATA response with no forwarded read outstanding");
					e = exp_data.pop_front();
				end else begin
					assert (exp_ack.size() > 0) else
						abort_run("MC_ACK response with no writeback outstanding");
					e = exp_ack.pop_front();
				end
				check_value("resp_addr", e.addr, resp_addr);
				check_value("resp_dest", e.dest, resp_dest);
				check_value("resp_src", TB_TILE, resp_src);
				check_value("resp_data", e.data, resp_data);
			end
		end
		resp_ready_prev = resp_ready;
	end

	initial begin
		#(NUM_TXNS * 40 * CLK_PERIOD);
		abort_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress",
			NUM_TXNS * 40));
	end

	initial begin
		reset           = 1'b1;
		fwd_valid       = 1'b0;
		fwd_addr        = '0;
		fwd_src         = '0;
		wb_valid        = 1'b0;
		wb_addr         = '0;
		wb_data         = '0;
		wb_mask         = '0;
		wb_src          = '0;
		mem_read_ready  = 1'b1;
		mem_write_ready = 1'b1;
		mem_resp_valid  = 1'b0;
		mem_resp_data   = '0;
		resp_ready      = 1'b1;
		resp_ready_prev = 1'b0;
		rng             = SEED;
		test_name       = "reset";
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			#1;
			check_idle_outputs();
		end
		reset = 1'b0;
		@(negedge clk);
		check_idle_outputs();
		@(posedge clk);
		#1;

		test_name = "forwarded read";
		send_read(32'h0000_1040, 4'd2);
		send_read(32'h8000_0fc0, 4'd9);
		wait_all_done();

		test_name = "writeback";
		random_line(wb_line);
		send_write(32'h0000_2000, wb_line, {MASK_WIDTH{1'b1}}, 4'd3);
		random_line(wb_line);
		send_write(32'h0000_2040, wb_line, 64'h00ff_0f00_f0f0_8001, 4'd11);
		wait_all_done();

		test_name = "read after write";
		random_line(wb_line);
		send_write(32'h0000_3000, wb_line, 64'hf0f0_ffff_0000_1234, 4'd1);
		wait_all_done();
		send_read(32'h0000_3000, 4'd6);
		send_read(32'h0000_2040, 4'd7);
		wait_all_done();

		// The first read is issued and then stalls the controller in WAIT_REPLY
		test_name  = "response back-pressure";
		resp_ready = 1'b0;
		send_read(32'h0000_4000, 4'd1);
		for (int i = 0; i < 3; i++) begin
			random_line(wb_line);
			send_write(32'h0000_5000 + 32'(i * 64), wb_line, {MASK_WIDTH{1'b1}}, 4'(i + 2));
		end
		check_value("wb_ready with full queue", 0, wb_ready);
		send_read(32'h0000_4040, 4'd4);
		send_read(32'h0000_4080, 4'd8);
		repeat (20) @(posedge clk);
		#1;
		// Two reads and three writebacks stay queued behind the stalled read
		check_value("memory requests not yet issued", 5, exp_rd.size() + exp_wr.size());
		resp_ready = 1'b1;
		wait_all_done();

		test_name = "memory back-pressure";
		mem_read_ready  = 1'b0;
		mem_write_ready = 1'b0;
		for (int i = 0; i < 3; i++)
			send_read(32'h0000_6000 + 32'(i * 64), 4'(i + 10));
		check_value("fwd_ready after three reads", 0, fwd_ready);
		repeat (12) @(posedge clk);
		#1;
		check_value("fwd_ready while memory busy", 0, fwd_ready);
		mem_read_ready  = 1'b1;
		mem_write_ready = 1'b1;
		wait_all_done();
		check_value("fwd_ready after memory ready", 1, fwd_ready);

		$display("Test passed");
		$finish;
	end

endmodule

/* verilog/coherence_ingress.sv */
// Input side. Queues forwarded reads and writebacks from the coherence network.
// Ready drops at depth minus one entries, so one slot is always spare.

`timescale 1ns/1ns

module coherence_ingress #(
	parameter int ADDR_WIDTH  = 32,
	parameter int LINE_WIDTH  = 512,
	parameter int MASK_WIDTH  = 64,
	parameter int QUEUE_DEPTH = 16
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fwd_valid,
	input  logic [ADDR_WIDTH-1:0] fwd_addr,
	input  mc_pkg::tile_id_t      fwd_src,
	output logic                  fwd_ready,
	input  logic                  wb_valid,
	input  logic [ADDR_WIDTH-1:0] wb_addr,
	input  logic [LINE_WIDTH-1:0] wb_data,
	input  logic [MASK_WIDTH-1:0] wb_mask,
	input  mc_pkg::tile_id_t      wb_src,
	output logic                  wb_ready,
	fwd_head_if.ingress           fwd,
	wb_head_if.ingress            wb
);

	localparam int FWD_W = ADDR_WIDTH + mc_pkg::TILE_BITS;
	localparam int WB_W  = ADDR_WIDTH + LINE_WIDTH + MASK_WIDTH + mc_pkg::TILE_BITS;

	logic [FWD_W-1:0] fwd_word;
	logic [FWD_W-1:0] fwd_q_head;
	logic             fwd_empty;
	logic             fwd_almost_full;
	logic [WB_W-1:0]  wb_word;
	logic [WB_W-1:0]  wb_q_head;
	logic             wb_empty;
	logic             wb_almost_full;

	assign fwd_ready = !fwd_almost_full;
	assign wb_ready  = !wb_almost_full;

	assign fwd_word = {fwd_addr, fwd_src};
	assign wb_word  = {wb_addr, wb_data, wb_mask, wb_src};

	msg_queue #(.WIDTH(FWD_W), .DEPTH(QUEUE_DEPTH)) fwd_queue (
		.clk         (clk),
		.reset       (reset),
		.push        (fwd_valid && fwd_ready),
		.push_data   (fwd_word),
		.pop         (fwd.pop),
		.head        (fwd_q_head),
		.empty       (fwd_empty),
		.almost_full (fwd_almost_full)
	);

	msg_queue #(.WIDTH(WB_W), .DEPTH(QUEUE_DEPTH)) wb_queue (
		.clk         (clk),
		.reset       (reset),
		.push        (wb_valid && wb_ready),
		.push_data   (wb_word),
		.pop         (wb.pop),
		.head        (wb_q_head),
		.empty       (wb_empty),
		.almost_full (wb_almost_full)
	);

	// Unpack the queue heads in the same field order as they were packed
	assign fwd.valid = !fwd_empty;
	assign {fwd.addr, fwd.src} = fwd_q_head;

	assign wb.valid = !wb_empty;
	assign {wb.addr, wb.data, wb.mask, wb.src} = wb_q_head;

endmodule

/* verilog/mc_if.sv */
// Links between the ingress, the issue controller and the egress.
// A queue head stays stable until pop, and order is a one-cycle pulse.

`timescale 1ns/1ns

// Head of the forwarded request queue
interface fwd_head_if #(
	parameter int ADDR_WIDTH = 32
);
	logic                   valid;
	logic [ADDR_WIDTH-1:0]  addr;
	mc_pkg::tile_id_t       src;
	logic                   pop;

	modport ingress (output valid, output addr, output src, input pop);
	modport ctrl    (input valid, input addr, input src, output pop);
endinterface

// Head of the writeback queue
interface wb_head_if #(
	parameter int ADDR_WIDTH = 32,
	parameter int LINE_WIDTH = 512,
	parameter int MASK_WIDTH = 64
);
	logic                   valid;
	logic [ADDR_WIDTH-1:0]  addr;
	logic [LINE_WIDTH-1:0]  data;
	logic [MASK_WIDTH-1:0]  mask;
	mc_pkg::tile_id_t       src;
	logic                   pop;

	modport ingress (output valid, output addr, output data, output mask, output src, input pop);
	modport ctrl    (input valid, input addr, input data, input mask, input src, output pop);
endinterface

// Reply order from the controller, done comes back once the response has left
interface reply_if #(
	parameter int ADDR_WIDTH = 32
);
	logic                   order;
	mc_pkg::resp_kind_t     kind;
	logic [ADDR_WIDTH-1:0]  addr;
	mc_pkg::tile_id_t       dest;
	logic                   done;

	modport ctrl   (output order, output kind, output addr, output dest, input done);
	modport egress (input order, input kind, input addr, input dest, output done);
endinterface

/* verilog/mc_pkg.sv */
// Shared widths, types and constants of the memory controller bridge.
// The defaults are only starting values, and the top level passes the real ones down.

package mc_pkg;

	// Default memory address width
	localparam int ADDR_WIDTH_DEF = 32;

	// Default cache line width in bits
	localparam int LINE_WIDTH_DEF = 512;

	// One dirty bit per byte of the line
	localparam int MASK_WIDTH_DEF = LINE_WIDTH_DEF / 8;

	// Default depth of each input queue
	localparam int QUEUE_DEPTH_DEF = 16;

	// Width of a tile number on the coherence network
	localparam int TILE_BITS = 4;

	typedef logic [TILE_BITS-1:0] tile_id_t;

	// A response carries either a data line or a bare acknowledge
	typedef logic [0:0] resp_kind_t;

	localparam resp_kind_t RESP_DATA   = 1'b0;
	localparam resp_kind_t RESP_MC_ACK = 1'b1;

	// Issue state machine, one memory transaction at a time
	typedef enum logic [1:0] {
		IDLE,
		ISSUE_READ,
		ISSUE_WRITE,
		WAIT_REPLY
	} ctrl_state_t;

endpackage

/* verilog/mem_controller_top.sv */
// Tile memory controller bridge between the coherence network and a memory port.
// One memory read or write is in flight at a time, responses leave in issue order.

`timescale 1ns/1ns

module mem_controller_top #(
	parameter int               ADDR_WIDTH  = mc_pkg::ADDR_WIDTH_DEF,
	parameter int               LINE_WIDTH  = mc_pkg::LINE_WIDTH_DEF,
	parameter int               MASK_WIDTH  = mc_pkg::MASK_WIDTH_DEF,
	parameter int               QUEUE_DEPTH = mc_pkg::QUEUE_DEPTH_DEF,
	parameter mc_pkg::tile_id_t TILE_ID     = '0
) (
	input  logic                  clk,
	input  logic                  reset,

	// Forwarded read requests from the network
	input  logic                  fwd_valid,
	input  logic [ADDR_WIDTH-1:0] fwd_addr,
	input  mc_pkg::tile_id_t      fwd_src,
	output logic                  fwd_ready,

	// Writebacks from the network
	input  logic                  wb_valid,
	input  logic [ADDR_WIDTH-1:0] wb_addr,
	input  logic [LINE_WIDTH-1:0] wb_data,
	input  logic [MASK_WIDTH-1:0] wb_mask,
	input  mc_pkg::tile_id_t      wb_src,
	output logic                  wb_ready,

	// Memory request port
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [LINE_WIDTH-1:0] mem_wdata,
	output logic [MASK_WIDTH-1:0] mem_mask,
	output logic                  mem_read,
	output logic                  mem_write,
	input  logic                  mem_read_ready,
	input  logic                  mem_write_ready,

	// Memory read data
	input  logic                  mem_resp_valid,
	input  logic [LINE_WIDTH-1:0] mem_resp_data,
	output logic                  mem_resp_ready,

	// Responses to the network
	input  logic                  resp_ready,
	output logic                  resp_valid,
	output mc_pkg::resp_kind_t    resp_kind,
	output logic [ADDR_WIDTH-1:0] resp_addr,
	output logic [LINE_WIDTH-1:0] resp_data,
	output mc_pkg::tile_id_t      resp_dest,
	output mc_pkg::tile_id_t      resp_src
);

	fwd_head_if #(.ADDR_WIDTH(ADDR_WIDTH)) fwd_head ();
	wb_head_if #(.ADDR_WIDTH(ADDR_WIDTH), .LINE_WIDTH(LINE_WIDTH), .MASK_WIDTH(MASK_WIDTH))
		wb_head ();
	reply_if #(.ADDR_WIDTH(ADDR_WIDTH)) reply ();

	coherence_ingress #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.LINE_WIDTH  (LINE_WIDTH),
		.MASK_WIDTH  (MASK_WIDTH),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) ingress (
		.clk (clk), .reset (reset),
		.fwd_valid (fwd_valid), .fwd_addr (fwd_addr), .fwd_src (fwd_src), .fwd_ready (fwd_ready),
		.wb_valid (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data), .wb_mask (wb_mask),
		.wb_src (wb_src), .wb_ready (wb_ready),
		.fwd (fwd_head.ingress), .wb (wb_head.ingress)
	);

	mem_issue_ctrl #(.ADDR_WIDTH(ADDR_WIDTH), .LINE_WIDTH(LINE_WIDTH), .MASK_WIDTH(MASK_WIDTH)) ctrl (
		.clk (clk), .reset (reset),
		.fwd (fwd_head.ctrl), .wb (wb_head.ctrl), .reply (reply.ctrl),
		.mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_mask (mem_mask),
		.mem_read (mem_read), .mem_write (mem_write),
		.mem_read_ready (mem_read_ready), .mem_write_ready (mem_write_ready)
	);

	response_egress #(.ADDR_WIDTH(ADDR_WIDTH), .LINE_WIDTH(LINE_WIDTH), .TILE_ID(TILE_ID)) egress (
		.clk (clk), .reset (reset),
		.reply (reply.egress),
		.mem_resp_valid (mem_resp_valid), .mem_resp_data (mem_resp_data),
		.mem_resp_ready (mem_resp_ready),
		.resp_ready (resp_ready), .resp_valid (resp_valid), .resp_kind (resp_kind),
		.resp_addr (resp_addr), .resp_data (resp_data),
		.resp_dest (resp_dest), .resp_src (resp_src)
	);

endmodule

/* verilog/mem_issue_ctrl.sv */
// Picks forwarded reads and writebacks in round robin and issues them to memory.
// Only one transaction is in flight, the next one starts after the egress reports done.

`timescale 1ns/1ns

module mem_issue_ctrl #(
	parameter int ADDR_WIDTH = 32,
	parameter int LINE_WIDTH = 512,
	parameter int MASK_WIDTH = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	fwd_head_if.ctrl              fwd,
	wb_head_if.ctrl               wb,
	reply_if.ctrl                 reply,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [LINE_WIDTH-1:0] mem_wdata,
	output logic [MASK_WIDTH-1:0] mem_mask,
	output logic                  mem_read,
	output logic                  mem_write,
	input  logic                  mem_read_ready,
	input  logic                  mem_write_ready
);

	mc_pkg::ctrl_state_t state;

	// High when the writeback queue was served last
	logic             last_wb;
	logic             pick_wb;
	logic             pick_fwd;
	mc_pkg::tile_id_t dest_q;

	// With both heads valid the one not served last wins
	assign pick_wb  = wb.valid && (!fwd.valid || !last_wb);
	assign pick_fwd = fwd.valid && !pick_wb;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state   <= mc_pkg::IDLE;
			last_wb <= 1'b0;
		end else begin
			case (state)
				mc_pkg::IDLE: begin
					if (pick_wb) begin
						state   <= mc_pkg::ISSUE_WRITE;
						last_wb <= 1'b1;
					end else if (pick_fwd) begin
						state   <= mc_pkg::ISSUE_READ;
						last_wb <= 1'b0;
					end
				end
				mc_pkg::ISSUE_READ: begin
					if (mem_read_ready)
						state <= mc_pkg::WAIT_REPLY;
				end
				mc_pkg::ISSUE_WRITE: begin
					if (mem_write_ready)
						state <= mc_pkg::WAIT_REPLY;
				end
				mc_pkg::WAIT_REPLY: begin
					if (reply.done)
						state <= mc_pkg::IDLE;
				end
				default: state <= mc_pkg::IDLE;
			endcase
		end
	end

	// Request fields are captured when the choice is made, the head stays put until pop
	always_ff @(posedge clk) begin
		if (state == mc_pkg::IDLE) begin
			if (pick_wb) begin
				mem_addr  <= wb.addr;
				mem_wdata <= wb.data;
				mem_mask  <= wb.mask;
				dest_q    <= wb.src;
			end else if (pick_fwd) begin
				mem_addr <= fwd.addr;
				dest_q   <= fwd.src;
			end
		end
	end

	// Strobes fire only while memory can take them and last one cycle
	assign mem_read  = (state == mc_pkg::ISSUE_READ) && mem_read_ready;
	assign mem_write = (state == mc_pkg::ISSUE_WRITE) && mem_write_ready;

	assign fwd.pop = mem_read;
	assign wb.pop  = mem_write;

	// The reply order goes out together with the memory strobe
	assign reply.order = mem_read || mem_write;
	assign reply.kind  = (state == mc_pkg::ISSUE_WRITE) ? mc_pkg::RESP_MC_ACK : mc_pkg::RESP_DATA;
	assign reply.addr  = mem_addr;
	assign reply.dest  = dest_q;

endmodule

/* verilog/msg_queue.sv */
// Synchronous circular FIFO with first-word fall-through on head.
// The writer must respect almost_full, a push into a full queue is not guarded.

`timescale 1ns/1ns

module msg_queue #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] head,
	output logic             empty,
	output logic             almost_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count unchanged
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign head        = mem[rd_ptr];
	assign empty       = (count == '0);
	assign almost_full = (count >= CNT_W'(DEPTH - 1));

endmodule

/* verilog/response_egress.sv */
// Output side. Buffers memory read data and builds the network responses.
// The data queue holds two lines, enough for the single outstanding read.

`timescale 1ns/1ns

module response_egress #(
	parameter int               ADDR_WIDTH = 32,
	parameter int               LINE_WIDTH = 512,
	parameter mc_pkg::tile_id_t TILE_ID    = '0
) (
	input  logic                  clk,
	input  logic                  reset,
	reply_if.egress               reply,
	input  logic                  mem_resp_valid,
	input  logic [LINE_WIDTH-1:0] mem_resp_data,
	output logic                  mem_resp_ready,
	input  logic                  resp_ready,
	output logic                  resp_valid,
	output mc_pkg::resp_kind_t    resp_kind,
	output logic [ADDR_WIDTH-1:0] resp_addr,
	output logic [LINE_WIDTH-1:0] resp_data,
	output mc_pkg::tile_id_t      resp_dest,
	output mc_pkg::tile_id_t      resp_src
);

	localparam int DATA_Q_DEPTH = 2;

	logic                  pend_valid;
	mc_pkg::resp_kind_t    pend_kind;
	logic [ADDR_WIDTH-1:0] pend_addr;
	mc_pkg::tile_id_t      pend_dest;
	logic [LINE_WIDTH-1:0] dq_head;
	logic                  dq_empty;
	logic                  dq_almost_full;
	logic                  data_ok;
	logic                  send;

	msg_queue #(.WIDTH(LINE_WIDTH), .DEPTH(DATA_Q_DEPTH)) data_queue (
		.clk         (clk),
		.reset       (reset),
		.push        (mem_resp_valid),
		.push_data   (mem_resp_data),
		.pop         (send && pend_kind == mc_pkg::RESP_DATA),
		.head        (dq_head),
		.empty       (dq_empty),
		.almost_full (dq_almost_full)
	);

	assign mem_resp_ready = !dq_almost_full;

	// An acknowledge needs no data, a read waits for its line
	assign data_ok = (pend_kind == mc_pkg::RESP_MC_ACK) || !dq_empty;
	assign send    = pend_valid && data_ok && resp_ready;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pend_valid <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= send;
			if (reply.order)
				pend_valid <= 1'b1;
			else if (send)
				pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reply.order) begin
			pend_kind <= reply.kind;
			pend_addr <= reply.addr;
			pend_dest <= reply.dest;
		end
		if (send) begin
			resp_kind <= pend_kind;
			resp_addr <= pend_addr;
			resp_dest <= pend_dest;
			resp_src  <= TILE_ID;
			resp_data <= (pend_kind == mc_pkg::RESP_DATA) ? dq_head : '0;
		end
	end

	// The controller sees completion in the cycle the response is on the network
	assign reply.done = resp_valid;

endmodule
